//--- Bender.yml
package:
  name: core_tile

sources:
  - files:
      - design/core_tile_pkg.sv
      - design/data_mem.sv
      - design/dmem_arbiter.sv
      - design/dbus_decode.sv
      - design/io_regs.sv
      - design/core_tile.sv
  - target: test
    files:
      - verification/core_tile_sva.sv
      - verification/core_tile_tb.sv

//--- design/core_tile.sv
`timescale 1ns/1ps

module core_tile import core_tile_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Core data bus
  input  logic      dbus_valid,
  input  logic      dbus_wr,
  input  addr_t     dbus_addr,
  input  word_t     dbus_wdata,
  input  size_t     dbus_size,
  output logic      dbus_stall,
  output logic      dbus_rsp_valid,
  output word_t     dbus_rdata,
  output logic      dbus_err,
  // DMA port
  input  logic      dma_en,
  input  logic      dma_ren,
  input  strb_t     dma_wen,
  input  addr_t     dma_addr,
  input  word_t     dma_wdata,
  output word_t     dma_rdata,
  // Descriptors
  output desc_t     data_desc,
  output logic      data_desc_valid,
  input  logic      data_desc_ready,
  output desc_t     ctrl_desc,
  output logic      ctrl_desc_valid,
  input  logic      ctrl_desc_ready,
  input  desc_t     in_desc,
  input  logic      in_desc_valid,
  output logic      in_desc_taken,
  // Slot lookup
  input  slot_ptr_t slot_ptr,
  output addr_t     slot_addr,
  // Broadcast and interrupt
  output logic      msg_valid,
  output addr_t     msg_addr,
  output word_t     msg_data,
  output strb_t     msg_strb,
  output logic      irq
);

  logic       core_go;
  logic       mem_req;
  strb_t      mem_we_mask;
  dmem_addr_t mem_addr;
  word_t      mem_wdata;
  word_t      mem_rdata;
  logic       io_wr;
  logic       io_rd;
  logic [6:0] io_off;
  strb_t      io_mask;
  word_t      io_wdata;
  word_t      io_rdata;
  logic       io_rd_hit;

  dmem_arbiter u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .dma_en      (dma_en),
    .dma_ren     (dma_ren),
    .dma_wen     (dma_wen),
    .dma_addr    (dma_addr),
    .dma_wdata   (dma_wdata),
    .dma_rdata   (dma_rdata),
    .dbus_valid  (dbus_valid),
    .dbus_stall  (dbus_stall),
    .core_go     (core_go),
    .mem_req     (mem_req),
    .mem_we_mask (mem_we_mask),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .irq         (irq)
  );

  dbus_decode u_decode (
    .clk            (clk),
    .rst            (rst),
    .core_go        (core_go),
    .dbus_wr        (dbus_wr),
    .dbus_addr      (dbus_addr),
    .dbus_wdata     (dbus_wdata),
    .dbus_size      (dbus_size),
    .mem_req        (mem_req),
    .mem_we_mask    (mem_we_mask),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .io_wr          (io_wr),
    .io_rd          (io_rd),
    .io_off         (io_off),
    .io_mask        (io_mask),
    .io_wdata       (io_wdata),
    .io_rdata       (io_rdata),
    .io_rd_hit      (io_rd_hit),
    .mem_rdata      (mem_rdata),
    .dbus_rsp_valid (dbus_rsp_valid),
    .dbus_rdata     (dbus_rdata),
    .dbus_err       (dbus_err),
    .msg_valid      (msg_valid),
    .msg_addr       (msg_addr),
    .msg_data       (msg_data),
    .msg_strb       (msg_strb)
  );

  io_regs u_io_regs (
    .clk             (clk),
    .rst             (rst),
    .io_wr           (io_wr),
    .io_rd           (io_rd),
    .io_off          (io_off),
    .io_mask         (io_mask),
    .io_wdata        (io_wdata),
    .io_rdata        (io_rdata),
    .io_rd_hit       (io_rd_hit),
    .data_desc       (data_desc),
    .data_desc_valid (data_desc_valid),
    .data_desc_ready (data_desc_ready),
    .ctrl_desc       (ctrl_desc),
    .ctrl_desc_valid (ctrl_desc_valid),
    .ctrl_desc_ready (ctrl_desc_ready),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .in_desc_taken   (in_desc_taken),
    .slot_ptr        (slot_ptr),
    .slot_addr       (slot_addr)
  );

endmodule

//--- design/core_tile_pkg.sv
package core_tile_pkg;

  ////////////////////////////////////////
  // Widths and address map
  ////////////////////////////////////////
  localparam int ADDR_WIDTH     = 16;
  localparam int DMEM_BYTES     = 4096;
  localparam int DMEM_BYTE_BITS = $clog2(DMEM_BYTES);

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [31:0]               word_t;
  typedef logic [3:0]                strb_t;
  typedef logic [DMEM_BYTE_BITS-3:0] dmem_addr_t;
  typedef logic [63:0]               desc_t;
  typedef logic [2:0]                slot_ptr_t;
  typedef logic [1:0]                size_t;

  // CPU data bus access sizes
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // Core constants
  localparam int    SLOT_COUNT      = 8;
  localparam addr_t SLOT_START_ADDR = 16'h200A;
  localparam addr_t SLOT_ADDR_STEP  = 16'h0800;
  localparam addr_t COHERENT_START  = 16'h0C00;
  localparam int    CORE_ID         = 5;
  localparam int    IO_SPACE        = 88;

  ////////////////////////////////////////
  // I/O offsets, low 7 address bits
  ////////////////////////////////////////
  localparam logic [6:0] IO_DATA_DESC   = 7'h00;
  localparam logic [6:0] IO_CTRL_DESC   = 7'h08;
  localparam logic [6:0] IO_SETTINGS    = 7'h10;
  localparam logic [6:0] IO_SLOT_INFO   = 7'h18;
  localparam logic [6:0] IO_STROBE_BASE = 7'h38;
  localparam logic [6:0] IO_SEND_DATA   = 7'h38;
  localparam logic [6:0] IO_SEND_CTRL   = 7'h39;
  localparam logic [6:0] IO_APPLY_SET   = 7'h3A;
  localparam logic [6:0] IO_SLOT_WR     = 7'h3B;
  localparam logic [6:0] IO_RELEASE     = 7'h3C;
  localparam logic [6:0] IO_RD_IN_DESC  = 7'h40;
  localparam logic [6:0] IO_RD_SETTINGS = 7'h48;
  localparam logic [6:0] IO_RD_STATUS   = 7'h50;
  localparam logic [6:0] IO_RD_ID       = 7'h54;

endpackage

//--- design/data_mem.sv
`timescale 1ns/1ps

module data_mem import core_tile_pkg::*; (
  input  logic       clk,
  input  logic       en,
  input  strb_t      we,
  input  dmem_addr_t addr,
  input  word_t      wdata,
  output word_t      rdata
);

  word_t mem [0:DMEM_BYTES/4-1];

  always_ff @(posedge clk) begin
    if (en) begin
      // Per-byte write lanes
      for (int b = 0; b < 4; b++) begin
        if (we[b]) begin
          mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
      // Read only when no lane is written
      if (we == '0) begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

//--- design/dbus_decode.sv
`timescale 1ns/1ps

module dbus_decode import core_tile_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       core_go,
  input  logic       dbus_wr,
  input  addr_t      dbus_addr,
  input  word_t      dbus_wdata,
  input  size_t      dbus_size,
  output logic       mem_req,
  output strb_t      mem_we_mask,
  output dmem_addr_t mem_addr,
  output word_t      mem_wdata,
  output logic       io_wr,
  output logic       io_rd,
  output logic [6:0] io_off,
  output strb_t      io_mask,
  output word_t      io_wdata,
  input  word_t      io_rdata,
  input  logic       io_rd_hit,
  input  word_t      mem_rdata,
  output logic       dbus_rsp_valid,
  output word_t      dbus_rdata,
  output logic       dbus_err,
  output logic       msg_valid,
  output addr_t      msg_addr,
  output word_t      msg_data,
  output strb_t      msg_strb
);

  logic  is_io;
  logic  mem_in_range;
  strb_t byte_mask;
  logic  access_err;
  logic  io_sel_q;

  assign is_io        = dbus_addr[ADDR_WIDTH-1];
  assign mem_in_range = dbus_addr < addr_t'(DMEM_BYTES);

  // Size code to byte lanes
  always_comb begin
    case (dbus_size)
      SIZE_BYTE: byte_mask = strb_t'(4'b0001 << dbus_addr[1:0]);
      SIZE_HALF: byte_mask = strb_t'(4'b0011 << dbus_addr[1:0]);
      default:   byte_mask = 4'b1111;
    endcase
  end

  ////////////////////////////////////////
  // Memory and I/O routing
  ////////////////////////////////////////
  assign mem_req     = core_go && !is_io && mem_in_range;
  assign mem_we_mask = dbus_wr ? byte_mask : '0;
  assign mem_addr    = dbus_addr[DMEM_BYTE_BITS-1:2];
  assign mem_wdata   = dbus_wdata;

  // Bit 6 splits the write half from the read half
  assign io_wr    = core_go && is_io && dbus_wr && !dbus_addr[6];
  assign io_rd    = core_go && is_io && !dbus_wr && dbus_addr[6];
  assign io_off   = dbus_addr[6:0];
  assign io_mask  = byte_mask;
  assign io_wdata = dbus_wdata;

  // Coherent writes go out as broadcast messages
  assign msg_valid = core_go && dbus_wr && !is_io && mem_in_range &&
                     (dbus_addr >= COHERENT_START);
  assign msg_addr  = dbus_addr;
  assign msg_data  = dbus_wdata;
  assign msg_strb  = byte_mask;

  ////////////////////////////////////////
  // Access errors and response
  ////////////////////////////////////////
  assign access_err =
    (!is_io && !mem_in_range) ||
    (is_io && (dbus_addr[ADDR_WIDTH-2:0] >= (ADDR_WIDTH-1)'(IO_SPACE))) ||
    (is_io && (dbus_wr == dbus_addr[6])) ||
    (is_io && (dbus_size != SIZE_BYTE) && (dbus_addr[6:3] == IO_STROBE_BASE[6:3]));

  always_ff @(posedge clk) begin
    if (rst) begin
      dbus_rsp_valid <= 1'b0;
      dbus_err       <= 1'b0;
      io_sel_q       <= 1'b0;
    end else begin
      dbus_rsp_valid <= core_go;
      io_sel_q       <= core_go && is_io;
      if (core_go && access_err) begin
        dbus_err <= 1'b1;
      end
    end
  end

  // Unmapped I/O reads return zero
  assign dbus_rdata = io_sel_q ? (io_rd_hit ? io_rdata : '0) : mem_rdata;

endmodule

//--- design/dmem_arbiter.sv
`timescale 1ns/1ps

module dmem_arbiter import core_tile_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       dma_en,
  input  logic       dma_ren,
  input  strb_t      dma_wen,
  input  addr_t      dma_addr,
  input  word_t      dma_wdata,
  output word_t      dma_rdata,
  input  logic       dbus_valid,
  output logic       dbus_stall,
  output logic       core_go,
  input  logic       mem_req,
  input  strb_t      mem_we_mask,
  input  dmem_addr_t mem_addr,
  input  word_t      mem_wdata,
  output word_t      mem_rdata,
  output logic       irq
);

  logic       dma_oob;
  logic       dma_go;
  logic       ram_en;
  strb_t      ram_we;
  dmem_addr_t ram_addr;
  word_t      ram_wdata;
  word_t      ram_rdata;

  // DMA always wins, core waits
  assign dbus_stall = dma_en;
  assign core_go    = dbus_valid && !dma_en;

  // Out of range DMA accesses never reach the memory
  assign dma_oob = dma_addr >= addr_t'(DMEM_BYTES);
  assign dma_go  = dma_en && !dma_oob && (dma_ren || (dma_wen != '0));

  always_comb begin
    if (dma_en) begin
      ram_en    = dma_go;
      ram_we    = dma_go ? dma_wen : '0;
      ram_addr  = dma_addr[DMEM_BYTE_BITS-1:2];
      ram_wdata = dma_wdata;
    end else begin
      ram_en    = mem_req;
      ram_we    = mem_we_mask;
      ram_addr  = mem_addr;
      ram_wdata = mem_wdata;
    end
  end

  data_mem u_data_mem (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // Shared read port, each side knows when its data is due
  assign dma_rdata = ram_rdata;
  assign mem_rdata = ram_rdata;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= 1'b0;
    end else if (dma_en && dma_oob) begin
      irq <= 1'b1;
    end
  end

endmodule

//--- design/io_regs.sv
`timescale 1ns/1ps

module io_regs import core_tile_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       io_wr,
  input  logic       io_rd,
  input  logic [6:0] io_off,
  input  strb_t      io_mask,
  input  word_t      io_wdata,
  output word_t      io_rdata,
  output logic       io_rd_hit,
  output desc_t      data_desc,
  output logic       data_desc_valid,
  input  logic       data_desc_ready,
  output desc_t      ctrl_desc,
  output logic       ctrl_desc_valid,
  input  logic       ctrl_desc_ready,
  input  desc_t      in_desc,
  input  logic       in_desc_valid,
  output logic       in_desc_taken,
  input  slot_ptr_t  slot_ptr,
  output addr_t      slot_addr
);

  desc_t      set_stage;
  desc_t      set_applied;
  word_t      slot_info;
  addr_t      slot_tbl [0:SLOT_COUNT-1];
  logic [7:0] wr_mask;
  desc_t      wr_din;
  desc_t      slot_info_next;
  slot_ptr_t  wr_slot;
  logic       strobe;
  logic       rd_in_desc;
  logic       rd_settings;
  logic       rd_status;
  logic       rd_id;

  function automatic desc_t merge_bytes(desc_t cur, logic [7:0] mask, desc_t din);
    desc_t res;
    res = cur;
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) begin
        res[i*8 +: 8] = din[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // Place the 32-bit write into the upper or lower word
  assign wr_mask        = {4'b0000, io_mask} << {io_off[2], 2'b00};
  assign wr_din         = {32'd0, io_wdata} << {io_off[2], 5'd0};
  assign slot_info_next = merge_bytes({32'd0, slot_info}, wr_mask, wr_din);
  assign wr_slot        = slot_ptr_t'(slot_info[31:24] - 8'd1);
  assign strobe         = io_wdata[0];

  ////////////////////////////////////////
  // Staging registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    // Descriptor staging is locked while its send is pending
    if (io_wr && io_off[6:3] == IO_DATA_DESC[6:3] && !data_desc_valid) begin
      data_desc <= merge_bytes(data_desc, wr_mask, wr_din);
    end
    if (io_wr && io_off[6:3] == IO_CTRL_DESC[6:3] && !ctrl_desc_valid) begin
      ctrl_desc <= merge_bytes(ctrl_desc, wr_mask, wr_din);
    end
    if (io_wr && io_off[6:3] == IO_SETTINGS[6:3]) begin
      set_stage <= merge_bytes(set_stage, wr_mask, wr_din);
    end
    if (io_wr && io_off[6:2] == IO_SLOT_INFO[6:2]) begin
      slot_info <= slot_info_next[31:0];
    end
  end

  ////////////////////////////////////////
  // Strobes and control state
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      data_desc_valid <= 1'b0;
      ctrl_desc_valid <= 1'b0;
      set_applied     <= '0;
      for (int s = 0; s < SLOT_COUNT; s++) begin
        slot_tbl[s] <= SLOT_START_ADDR + addr_t'(s) * SLOT_ADDR_STEP;
      end
    end else begin
      if (data_desc_valid && data_desc_ready) begin
        data_desc_valid <= 1'b0;
      end else if (io_wr && io_off == IO_SEND_DATA && strobe) begin
        data_desc_valid <= 1'b1;
      end
      if (ctrl_desc_valid && ctrl_desc_ready) begin
        ctrl_desc_valid <= 1'b0;
      end else if (io_wr && io_off == IO_SEND_CTRL && strobe) begin
        ctrl_desc_valid <= 1'b1;
      end
      if (io_wr && io_off == IO_APPLY_SET && strobe) begin
        set_applied <= set_stage;
      end
      // Slot numbers in the info word start at one
      if (io_wr && io_off == IO_SLOT_WR && strobe) begin
        slot_tbl[wr_slot] <= slot_info[ADDR_WIDTH-1:0];
      end
    end
  end

  assign in_desc_taken = io_wr && io_off == IO_RELEASE && strobe;
  assign slot_addr     = slot_tbl[slot_ptr];

  ////////////////////////////////////////
  // Read path, one cycle
  ////////////////////////////////////////
  assign rd_in_desc  = io_off[6:3] == IO_RD_IN_DESC[6:3];
  assign rd_settings = io_off[6:3] == IO_RD_SETTINGS[6:3];
  assign rd_status   = io_off[6:2] == IO_RD_STATUS[6:2];
  assign rd_id       = io_off[6:2] == IO_RD_ID[6:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_hit <= 1'b0;
    end else begin
      io_rd_hit <= io_rd && (rd_in_desc || rd_settings || rd_status || rd_id);
    end
  end

  always_ff @(posedge clk) begin
    if (io_rd) begin
      if (rd_in_desc) begin
        if (!in_desc_valid) begin
          io_rdata <= '0;
        end else begin
          io_rdata <= io_off[2] ? in_desc[63:32] : in_desc[31:0];
        end
      end else if (rd_settings) begin
        io_rdata <= io_off[2] ? set_applied[63:32] : set_applied[31:0];
      end else if (rd_status) begin
        io_rdata <= {23'd0, ctrl_desc_ready, 7'd0, data_desc_ready};
      end else if (rd_id) begin
        io_rdata <= word_t'(CORE_ID);
      end
    end
  end

endmodule

//--- sim.f
design/core_tile_pkg.sv
design/data_mem.sv
design/dmem_arbiter.sv
design/dbus_decode.sv
design/io_regs.sv
design/core_tile.sv
verification/core_tile_sva.sv
verification/core_tile_tb.sv

//--- verification/core_tile_sva.sv
`timescale 1ns/1ps

module core_tile_sva import core_tile_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  dbus_valid,
  input logic  dbus_stall,
  input logic  dbus_rsp_valid,
  input logic  dma_en,
  input desc_t data_desc,
  input logic  data_desc_valid,
  input logic  data_desc_ready,
  input desc_t ctrl_desc,
  input logic  ctrl_desc_valid,
  input logic  ctrl_desc_ready
);

  int fail_count = 0;

  // Each accepted command gets its response one cycle later
  rsp_after_accept: assert property (@(posedge clk) disable iff (rst)
    (dbus_valid && !dbus_stall) |=> dbus_rsp_valid)
    else begin
      $error("No response one cycle after an accepted command");
      fail_count++;
    end

  rsp_needs_accept: assert property (@(posedge clk) disable iff (rst)
    dbus_rsp_valid |-> $past(dbus_valid && !dbus_stall))
    else begin
      $error("Response without an accepted command");
      fail_count++;
    end

  stall_only_for_dma: assert property (@(posedge clk) disable iff (rst)
    dbus_stall |-> dma_en)
    else begin
      $error("Core stalled without DMA activity");
      fail_count++;
    end

  ////////////////////////////////////////
  // Descriptor outputs hold until taken
  ////////////////////////////////////////
  data_desc_hold: assert property (@(posedge clk) disable iff (rst)
    (data_desc_valid && !data_desc_ready) |=> (data_desc_valid && $stable(data_desc)))
    else begin
      $error("Data descriptor changed while ready was low");
      fail_count++;
    end

  ctrl_desc_hold: assert property (@(posedge clk) disable iff (rst)
    (ctrl_desc_valid && !ctrl_desc_ready) |=> (ctrl_desc_valid && $stable(ctrl_desc)))
    else begin
      $error("Control descriptor changed while ready was low");
      fail_count++;
    end

endmodule

bind core_tile core_tile_sva sva0 (
  .clk             (clk),
  .rst             (rst),
  .dbus_valid      (dbus_valid),
  .dbus_stall      (dbus_stall),
  .dbus_rsp_valid  (dbus_rsp_valid),
  .dma_en          (dma_en),
  .data_desc       (data_desc),
  .data_desc_valid (data_desc_valid),
  .data_desc_ready (data_desc_ready),
  .ctrl_desc       (ctrl_desc),
  .ctrl_desc_valid (ctrl_desc_valid),
  .ctrl_desc_ready (ctrl_desc_ready)
);

//--- verification/core_tile_tb.sv
`timescale 1ns/1ps

module core_tile_tb import core_tile_pkg::*; ();

  localparam int CLK_HALF       = 20;
  localparam int DRV            = 2;
  localparam int TIMEOUT_CYCLES = 600;
  localparam int MEM_BASE       = 'h100;

  logic      clk;
  logic      rst;
  logic      dbus_valid;
  logic      dbus_wr;
  addr_t     dbus_addr;
  word_t     dbus_wdata;
  size_t     dbus_size;
  logic      dbus_stall;
  logic      dbus_rsp_valid;
  word_t     dbus_rdata;
  logic      dbus_err;
  logic      dma_en;
  logic      dma_ren;
  strb_t     dma_wen;
  addr_t     dma_addr;
  word_t     dma_wdata;
  word_t     dma_rdata;
  desc_t     data_desc;
  logic      data_desc_valid;
  logic      data_desc_ready;
  desc_t     ctrl_desc;
  logic      ctrl_desc_valid;
  logic      ctrl_desc_ready;
  desc_t     in_desc;
  logic      in_desc_valid;
  logic      in_desc_taken;
  slot_ptr_t slot_ptr;
  addr_t     slot_addr;
  logic      msg_valid;
  addr_t     msg_addr;
  word_t     msg_data;
  strb_t     msg_strb;
  logic      irq;

  int    seed   = 32'h56c2;
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  word_t shadow [0:DMEM_BYTES/4-1];
  logic  msg_seen;
  addr_t msg_addr_seen;
  word_t msg_data_seen;
  strb_t msg_strb_seen;
  logic  taken_seen;

  core_tile dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference helpers
  ////////////////////////////////////////
  function automatic strb_t size_lanes(size_t size, logic [1:0] low);
    strb_t lanes;
    lanes = '0;
    case (size)
      SIZE_BYTE: lanes[low] = 1'b1;
      SIZE_HALF: lanes = low[1] ? 4'b1100 : 4'b0011;
      default:   lanes = 4'b1111;
    endcase
    return lanes;
  endfunction

  // Narrow writes carry their data on every lane
  function automatic word_t spread_data(size_t size, word_t value);
    case (size)
      SIZE_BYTE: return {4{value[7:0]}};
      SIZE_HALF: return {2{value[15:0]}};
      default:   return value;
    endcase
  endfunction

  function automatic word_t lane_bits(strb_t lanes);
    word_t bits;
    for (int b = 0; b < 4; b++) begin
      bits[b*8 +: 8] = {8{lanes[b]}};
    end
    return bits;
  endfunction

  function automatic addr_t align_addr(size_t size, addr_t addr);
    case (size)
      SIZE_BYTE: return addr;
      SIZE_HALF: return {addr[15:1], 1'b0};
      default:   return {addr[15:2], 2'b00};
    endcase
  endfunction

  task automatic expect_equal(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic to_drive_point();
    @(posedge clk);
    #DRV;
  endtask

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////
  task automatic core_access(input logic wr, input addr_t addr, input word_t wdata,
                             input size_t size, output word_t rdata);
    to_drive_point();
    dbus_valid = 1'b1;
    dbus_wr    = wr;
    dbus_addr  = addr;
    dbus_wdata = wdata;
    dbus_size  = size;
    @(negedge clk);
    // Command held while DMA owns the memory
    while (dbus_stall) begin
      @(negedge clk);
    end
    msg_seen      = msg_valid;
    msg_addr_seen = msg_addr;
    msg_data_seen = msg_data;
    msg_strb_seen = msg_strb;
    taken_seen    = in_desc_taken;
    to_drive_point();
    dbus_valid = 1'b0;
    dbus_wr    = 1'b0;
    @(negedge clk);
    expect_equal("dbus_rsp_valid", dbus_rsp_valid, 1'b1);
    rdata = dbus_rdata;
  endtask

  task automatic core_write(input addr_t addr, input word_t wdata, input size_t size);
    word_t unused;
    core_access(1'b1, addr, wdata, size, unused);
  endtask

  task automatic core_read(input addr_t addr, input size_t size, output word_t rdata);
    core_access(1'b0, addr, '0, size, rdata);
  endtask

  task automatic dma_access(input logic ren, input strb_t wen, input addr_t addr,
                            input word_t wdata, output word_t rdata);
    to_drive_point();
    dma_en    = 1'b1;
    dma_ren   = ren;
    dma_wen   = wen;
    dma_addr  = addr;
    dma_wdata = wdata;
    to_drive_point();
    dma_en  = 1'b0;
    dma_ren = 1'b0;
    dma_wen = '0;
    @(negedge clk);
    rdata = dma_rdata;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic memory_path();
    word_t data;
    word_t got;
    addr_t addr;
    size_t size;
    word_t bits;
    for (int w = 0; w < 16; w++) begin
      data = $random(seed);
      shadow[MEM_BASE/4 + w] = data;
      dma_access(1'b0, 4'b1111, addr_t'(MEM_BASE + w*4), data, got);
    end
    // Core reads DMA data and only its own lanes count
    for (int i = 0; i < 16; i++) begin
      size = size_t'($unsigned($random(seed)) % 3);
      addr = align_addr(size, addr_t'(MEM_BASE + ($random(seed) & 'h3F)));
      bits = lane_bits(size_lanes(size, addr[1:0]));
      core_read(addr, size, got);
      expect_equal("dbus_rdata", got & bits, shadow[addr[11:2]] & bits);
    end
    for (int i = 0; i < 16; i++) begin
      size = size_t'($unsigned($random(seed)) % 3);
      addr = align_addr(size, addr_t'(MEM_BASE + ($random(seed) & 'h3F)));
      data = spread_data(size, $random(seed));
      bits = lane_bits(size_lanes(size, addr[1:0]));
      core_write(addr, data, size);
      expect_equal("msg_valid", msg_seen, 1'b0);
      shadow[addr[11:2]] = (shadow[addr[11:2]] & ~bits) | (data & bits);
    end
    for (int w = 0; w < 16; w++) begin
      dma_access(1'b1, 4'b0000, addr_t'(MEM_BASE + w*4), '0, got);
      expect_equal("dma_rdata", got, shadow[MEM_BASE/4 + w]);
    end
  endtask

  task automatic dma_core_collision();
    word_t got;
    to_drive_point();
    dma_en     = 1'b1;
    dma_ren    = 1'b1;
    dma_addr   = addr_t'(MEM_BASE + 'h10);
    dbus_valid = 1'b1;
    dbus_wr    = 1'b0;
    dbus_addr  = addr_t'(MEM_BASE + 'h24);
    dbus_size  = SIZE_WORD;
    @(negedge clk);
    expect_equal("dbus_stall", dbus_stall, 1'b1);
    to_drive_point();
    dma_en  = 1'b0;
    dma_ren = 1'b0;
    @(negedge clk);
    // Core accepted now with DMA data due in the same cycle
    expect_equal("dbus_stall", dbus_stall, 1'b0);
    expect_equal("dbus_rsp_valid", dbus_rsp_valid, 1'b0);
    expect_equal("dma_rdata", dma_rdata, shadow[MEM_BASE/4 + 4]);
    to_drive_point();
    dbus_valid = 1'b0;
    @(negedge clk);
    expect_equal("dbus_rsp_valid", dbus_rsp_valid, 1'b1);
    expect_equal("dbus_rdata", dbus_rdata, shadow[MEM_BASE/4 + 9]);
    expect_equal("irq", irq, 1'b0);
    dma_access(1'b0, 4'b1111, 16'h1000, 32'hDEAD_BEEF, got);
    expect_equal("irq", irq, 1'b1);
    dma_access(1'b1, 4'b0000, addr_t'(MEM_BASE), '0, got);
    expect_equal("dma_rdata", got, shadow[MEM_BASE/4]);
    expect_equal("irq", irq, 1'b1);
  endtask

  task automatic descriptor_send();
    desc_t data_val;
    desc_t ctrl_val;
    data_val = {$random(seed), $random(seed)};
    ctrl_val = {$random(seed), $random(seed)};
    core_write(16'h8000, data_val[31:0], SIZE_WORD);
    core_write(16'h8004, data_val[63:32], SIZE_WORD);
    core_write(16'h8008, ctrl_val[31:0], SIZE_WORD);
    core_write(16'h800C, ctrl_val[63:32], SIZE_WORD);
    core_write(16'h8039, 32'h0202_0202, SIZE_BYTE);
    expect_equal("ctrl_desc_valid", ctrl_desc_valid, 1'b0);
    expect_equal("data_desc_valid", data_desc_valid, 1'b0);
    core_write(16'h8038, 32'h0101_0101, SIZE_BYTE);
    expect_equal("data_desc_valid", data_desc_valid, 1'b1);
    expect_equal("data_desc", data_desc, data_val);
    core_write(16'h8039, 32'h0101_0101, SIZE_BYTE);
    expect_equal("ctrl_desc_valid", ctrl_desc_valid, 1'b1);
    expect_equal("ctrl_desc", ctrl_desc, ctrl_val);
    repeat (3) begin
      @(negedge clk);
      expect_equal("data_desc_valid", data_desc_valid, 1'b1);
      expect_equal("data_desc", data_desc, data_val);
      expect_equal("ctrl_desc_valid", ctrl_desc_valid, 1'b1);
    end
    // Valid drops after the handshake cycle
    to_drive_point();
    data_desc_ready = 1'b1;
    @(negedge clk);
    expect_equal("data_desc_valid", data_desc_valid, 1'b1);
    to_drive_point();
    data_desc_ready = 1'b0;
    ctrl_desc_ready = 1'b1;
    @(negedge clk);
    expect_equal("data_desc_valid", data_desc_valid, 1'b0);
    expect_equal("ctrl_desc_valid", ctrl_desc_valid, 1'b1);
    to_drive_point();
    ctrl_desc_ready = 1'b0;
    @(negedge clk);
    expect_equal("ctrl_desc_valid", ctrl_desc_valid, 1'b0);
  endtask

  task automatic register_reads();
    desc_t set_val;
    desc_t in_val;
    word_t got;
    set_val = {$random(seed), $random(seed)};
    in_val  = {$random(seed), $random(seed)};
    core_write(16'h8010, set_val[31:0], SIZE_WORD);
    core_write(16'h8014, set_val[63:32], SIZE_WORD);
    core_read(16'h8048, SIZE_WORD, got);
    expect_equal("dbus_rdata (settings low)", got, '0);
    core_read(16'h804C, SIZE_WORD, got);
    expect_equal("dbus_rdata (settings high)", got, '0);
    core_write(16'h803A, 32'h0101_0101, SIZE_BYTE);
    core_read(16'h8048, SIZE_WORD, got);
    expect_equal("dbus_rdata (settings low)", got, set_val[31:0]);
    core_read(16'h804C, SIZE_WORD, got);
    expect_equal("dbus_rdata (settings high)", got, set_val[63:32]);
    to_drive_point();
    data_desc_ready = 1'b1;
    core_read(16'h8050, SIZE_WORD, got);
    expect_equal("dbus_rdata (status)", got, 32'h0000_0001);
    to_drive_point();
    data_desc_ready = 1'b0;
    ctrl_desc_ready = 1'b1;
    core_read(16'h8050, SIZE_WORD, got);
    expect_equal("dbus_rdata (status)", got, 32'h0000_0100);
    to_drive_point();
    ctrl_desc_ready = 1'b0;
    core_read(16'h8054, SIZE_WORD, got);
    expect_equal("dbus_rdata (core id)", got, 32'd5);
    // Incoming descriptor stays hidden until valid
    to_drive_point();
    in_desc = in_val;
    core_read(16'h8040, SIZE_WORD, got);
    expect_equal("dbus_rdata (in_desc low)", got, '0);
    to_drive_point();
    in_desc_valid = 1'b1;
    core_read(16'h8040, SIZE_WORD, got);
    expect_equal("dbus_rdata (in_desc low)", got, in_val[31:0]);
    core_read(16'h8044, SIZE_WORD, got);
    expect_equal("dbus_rdata (in_desc high)", got, in_val[63:32]);
    core_write(16'h803C, 32'h0101_0101, SIZE_BYTE);
    expect_equal("in_desc_taken", taken_seen, 1'b1);
    expect_equal("in_desc_taken", in_desc_taken, 1'b0);
    to_drive_point();
    in_desc_valid = 1'b0;
  endtask

  task automatic check_slots(input int changed, input addr_t new_addr);
    addr_t exp;
    addr_t base_addr;
    base_addr = SLOT_START_ADDR;
    for (int s = 0; s < SLOT_COUNT; s++) begin
      exp = base_addr;
      if (s == changed) begin
        exp = new_addr;
      end
      to_drive_point();
      slot_ptr = slot_ptr_t'(s);
      @(negedge clk);
      expect_equal($sformatf("slot_addr[%0d]", s), slot_addr, exp);
      base_addr = base_addr + SLOT_ADDR_STEP;
    end
  endtask

  task automatic slot_table_update();
    int    pick;
    addr_t new_addr;
    pick     = $unsigned($random(seed)) % SLOT_COUNT;
    new_addr = $random(seed);
    check_slots(-1, '0);
    // Info word slot numbers count from one
    core_write(16'h8018, {8'(pick + 1), 8'h00, new_addr}, SIZE_WORD);
    check_slots(-1, '0);
    core_write(16'h803B, 32'h0101_0101, SIZE_BYTE);
    check_slots(pick, new_addr);
  endtask

  task automatic expect_message(addr_t addr, word_t data, strb_t strb);
    expect_equal("msg_valid", msg_seen, 1'b1);
    expect_equal("msg_addr", msg_addr_seen, addr);
    expect_equal("msg_data", msg_data_seen, data);
    expect_equal("msg_strb", msg_strb_seen, strb);
  endtask

  task automatic coherent_messages();
    word_t first;
    word_t data;
    word_t got;
    first = $random(seed);
    core_write(16'h0C40, first, SIZE_WORD);
    expect_message(16'h0C40, first, 4'b1111);
    data = spread_data(SIZE_HALF, $random(seed));
    core_write(16'h0D12, data, SIZE_HALF);
    expect_message(16'h0D12, data, 4'b1100);
    data = spread_data(SIZE_BYTE, $random(seed));
    core_write(16'h0FF1, data, SIZE_BYTE);
    expect_message(16'h0FF1, data, 4'b0010);
    // Just below the boundary
    core_write(16'h0BFC, data, SIZE_WORD);
    expect_equal("msg_valid", msg_seen, 1'b0);
    expect_equal("dbus_err", dbus_err, 1'b0);
    core_read(16'h8000, SIZE_WORD, got);
    expect_equal("dbus_err", dbus_err, 1'b1);
    core_read(16'h0C40, SIZE_WORD, got);
    expect_equal("dbus_rdata", got, first);
    expect_equal("dbus_err", dbus_err, 1'b1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    rst             = 1'b1;
    dbus_valid      = 1'b0;
    dbus_wr         = 1'b0;
    dbus_addr       = '0;
    dbus_wdata      = '0;
    dbus_size       = SIZE_WORD;
    dma_en          = 1'b0;
    dma_ren         = 1'b0;
    dma_wen         = '0;
    dma_addr        = '0;
    dma_wdata       = '0;
    data_desc_ready = 1'b0;
    ctrl_desc_ready = 1'b0;
    in_desc         = '0;
    in_desc_valid   = 1'b0;
    slot_ptr        = '0;
    repeat (4) @(posedge clk);
    #DRV;
    rst = 1'b0;

    memory_path();
    dma_core_collision();
    descriptor_send();
    register_reads();
    slot_table_update();
    coherent_messages();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut0.sva0.fail_count);
    if (errors == 0 && dut0.sva0.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
